/* rv32i_backend.f */
design/rv32i_pkg.sv
design/rv32i_regfile.sv
design/rv32i_decode.sv
design/rv32i_execute.sv
design/rv32i_memory.sv
design/rv32i_writeback.sv
design/rv32i_backend.sv
test/rv32i_backend_props.sv
test/rv32i_backend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rv32i_backend_tb \
    -f rv32i_backend.f > build.log 2>&1 ||
    { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vrv32i_backend_tb > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* test/rv32i_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_backend_tb;

    localparam int OP_IMM   = 'h13;
    localparam int OP_LOAD  = 'h03;
    localparam int OP_LUI   = 'h37;
    localparam int OP_AUIPC = 'h17;
    localparam int ALT      = 'h20;

    typedef struct packed {
        logic [31:0] word;
        logic        writes;
        logic [4:0]  rd;
        logic [31:0] data;
    } entry_t;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        instr_ready_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    entry_t table_q[$];
    entry_t exp_e;
    int     n_writes     = 0;
    int     limit        = 0;
    int     cycles       = 0;
    int     chk_idx      = 0;
    int     seen         = 0;
    int     start_checks = 0;
    int     start_errors = 0;
    int     wb_checks    = 0;
    int     wb_errors    = 0;
    int     idle;

    rv32i_backend #(
        .DMEM_ADDR_BITS (8)
    ) UUT (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #50 clk_i = ~clk_i;

    // instruction encoders
    function automatic logic [31:0] i_type(input int op, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] r_type(input int f3, input int f7, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(input int f3, input int rs2, input int rs1,
                                           input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] u_type(input int op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    task automatic add_write(input logic [31:0] word, input int rd, input logic [31:0] data);
        entry_t e;
        e.word   = word;
        e.writes = 1'b1;
        e.rd     = rd[4:0];
        e.data   = data;
        table_q.push_back(e);
        n_writes++;
    endtask

    task automatic add_silent(input logic [31:0] word);
        entry_t e;
        e.word   = word;
        e.writes = 1'b0;
        e.rd     = 5'd0;
        e.data   = 32'h0;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add_write(i_type(OP_IMM, 0, 1, 0, 5), 1, 32'h00000005);
        add_write(i_type(OP_IMM, 0, 2, 0, -3), 2, 32'hFFFFFFFD);
        add_write(r_type(0, 0, 3, 1, 2), 3, 32'h00000002);
        add_write(r_type(0, ALT, 4, 1, 2), 4, 32'h00000008);
        add_write(r_type(0, ALT, 5, 2, 1), 5, 32'hFFFFFFF8);
        add_write(r_type(4, 0, 6, 1, 2), 6, 32'hFFFFFFF8);
        add_write(r_type(6, 0, 7, 1, 2), 7, 32'hFFFFFFFD);
        add_write(r_type(7, 0, 8, 1, 2), 8, 32'h00000005);
        add_write(i_type(OP_IMM, 0, 9, 0, 31), 9, 32'h0000001F);
        add_write(r_type(1, 0, 10, 1, 9), 10, 32'h80000000);
        add_write(r_type(5, 0, 11, 2, 9), 11, 32'h00000001);
        add_write(r_type(5, ALT, 12, 2, 9), 12, 32'hFFFFFFFF);
        add_write(i_type(OP_IMM, 1, 13, 1, 4), 13, 32'h00000050);
        add_write(i_type(OP_IMM, 5, 14, 2, 4), 14, 32'h0FFFFFFF);
        add_write(i_type(OP_IMM, 5, 15, 2, 'h401), 15, 32'hFFFFFFFE);
        add_write(i_type(OP_IMM, 4, 16, 1, -1), 16, 32'hFFFFFFFA);
        add_write(i_type(OP_IMM, 6, 17, 1, 'hF0), 17, 32'h000000F5);
        add_write(i_type(OP_IMM, 7, 18, 2, 'h7FF), 18, 32'h000007FD);
        // signed and unsigned order differ for -3 and 5
        add_write(r_type(2, 0, 19, 2, 1), 19, 32'h00000001);
        add_write(r_type(3, 0, 20, 2, 1), 20, 32'h00000000);
        add_write(i_type(OP_IMM, 2, 21, 1, -1), 21, 32'h00000000);
        add_write(i_type(OP_IMM, 3, 22, 1, -1), 22, 32'h00000001);
        add_write(u_type(OP_LUI, 23, 'hABCDE), 23, 32'hABCDE000);
        // entry 23, pc 0x5c
        add_write(u_type(OP_AUIPC, 24, 'h12345), 24, 32'h1234505C);
        add_silent(i_type(OP_IMM, 0, 0, 1, 7));
        add_write(r_type(0, 0, 25, 0, 1), 25, 32'h00000005);
        // beq, dropped by decode
        add_silent(32'h00000063);
        add_write(u_type(OP_LUI, 26, 'h89ABD), 26, 32'h89ABD000);
        add_write(i_type(OP_IMM, 0, 26, 26, -'h211), 26, 32'h89ABCDEF);
        add_write(i_type(OP_IMM, 0, 27, 0, 'h100), 27, 32'h00000100);
        add_silent(s_type(2, 26, 27, 0));
        add_write(i_type(OP_LOAD, 2, 28, 27, 0), 28, 32'h89ABCDEF);
        add_write(i_type(OP_LOAD, 0, 29, 27, 0), 29, 32'hFFFFFFEF);
        add_write(i_type(OP_LOAD, 0, 29, 27, 1), 29, 32'hFFFFFFCD);
        add_write(i_type(OP_LOAD, 0, 29, 27, 2), 29, 32'hFFFFFFAB);
        add_write(i_type(OP_LOAD, 0, 29, 27, 3), 29, 32'hFFFFFF89);
        add_write(i_type(OP_LOAD, 4, 29, 27, 0), 29, 32'h000000EF);
        add_write(i_type(OP_LOAD, 4, 29, 27, 1), 29, 32'h000000CD);
        add_write(i_type(OP_LOAD, 4, 29, 27, 2), 29, 32'h000000AB);
        add_write(i_type(OP_LOAD, 4, 29, 27, 3), 29, 32'h00000089);
        add_write(i_type(OP_LOAD, 1, 29, 27, 0), 29, 32'hFFFFCDEF);
        add_write(i_type(OP_LOAD, 1, 29, 27, 2), 29, 32'hFFFF89AB);
        add_write(i_type(OP_LOAD, 5, 29, 27, 0), 29, 32'h0000CDEF);
        add_write(i_type(OP_LOAD, 5, 29, 27, 2), 29, 32'h000089AB);
        // word at 0x100 ends as 1ff50005
        add_silent(s_type(1, 1, 27, 2));
        add_silent(s_type(1, 2, 27, 0));
        add_silent(s_type(0, 9, 27, 3));
        add_silent(s_type(0, 1, 27, 0));
        add_silent(s_type(0, 20, 27, 1));
        add_silent(s_type(0, 17, 27, 2));
        add_write(i_type(OP_LOAD, 2, 30, 27, 0), 30, 32'h1FF50005);
        add_write(r_type(0, 0, 31, 30, 1), 31, 32'h1FF5000A);
        add_silent(s_type(2, 31, 27, 4));
        add_write(i_type(OP_LOAD, 2, 5, 27, 4), 5, 32'h1FF5000A);
        add_write(i_type(OP_LOAD, 5, 6, 27, 6), 6, 32'h00001FF5);
        add_write(i_type(OP_LOAD, 0, 7, 27, 6), 7, 32'hFFFFFFF5);
        add_write(i_type(OP_IMM, 0, 3, 3, 1), 3, 32'h00000003);
        add_write(i_type(OP_IMM, 0, 3, 3, 1), 3, 32'h00000004);
        add_write(r_type(1, 0, 4, 3, 3), 4, 32'h00000040);
    endtask

    // starts and ends on a falling edge, ready is settled there
    task automatic dispatch(input logic [31:0] word);
        instr_valid_i = 1'b1;
        instr_i       = word;
        while (!instr_ready_o) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d writebacks seen",
                     cycles, seen, n_writes);
            $display("%0d checks, %0d errors", start_checks + wb_checks,
                     start_errors + wb_errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    // writebacks come in program order, skip the entries that write nothing
    always @(negedge clk_i) begin
        if (!reset_i && wb_valid_o) begin
            while (chk_idx < table_q.size() && !table_q[chk_idx].writes) begin
                chk_idx++;
            end
            wb_checks++;
            assert (chk_idx < table_q.size()) else begin
                $display("unexpected writeback to x%0d at %0t after the last entry",
                         wb_rd_o, $time);
                wb_errors++;
            end
            if (chk_idx < table_q.size()) begin
                exp_e = table_q[chk_idx];
                wb_checks++;
                assert (wb_rd_o == exp_e.rd && wb_data_o == exp_e.data) else begin
                    $display("[FAIL] %0t entry %0d wrote x%0d = %h, expected x%0d = %h",
                             $time, chk_idx, wb_rd_o, wb_data_o, exp_e.rd, exp_e.data);
                    wb_errors++;
                end
                chk_idx++;
                seen++;
            end
        end
    end

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        void'($urandom(23));
        build_table();
        limit = 16 + 10 * table_q.size();
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        // quiet pipeline before the first dispatch
        repeat (3) begin
            start_checks++;
            assert (instr_ready_o && !wb_valid_o) else begin
                $display("[FAIL] %0t after reset instr_ready_o = %b, wb_valid_o = %b",
                         $time, instr_ready_o, wb_valid_o);
                start_errors++;
            end
            @(negedge clk_i);
        end
        foreach (table_q[i]) begin
            idle = $urandom % 3;
            repeat (idle) @(negedge clk_i);
            dispatch(table_q[i].word);
        end
        while (seen < n_writes) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        $display("%0d checks, %0d errors", start_checks + wb_checks, start_errors + wb_errors);
        if (start_errors + wb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/rv32i_backend_props.sv */
`timescale 1ns/1ps
`default_nettype none

// checks on the decode handshake, issued loads and the writeback tag
module rv32i_backend_props import rv32i_pkg::*; (
    input wire logic       clk_i,
    input wire logic       reset_i,
    input wire logic       instr_valid_i,
    input wire logic       instr_ready_i,
    input wire logic [5:0] wb_busy_rd_i,
    input wire exe_pkt_t   exe_pkt_i
);

    logic [XLEN-1:0] addr;
    logic            is_load;

    // same address that execute forms one cycle later
    assign addr    = exe_pkt_i.rs1_data + exe_pkt_i.imm;
    assign is_load = exe_pkt_i.valid && exe_pkt_i.ctrl.mem_read;

    half_load_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        (is_load && (exe_pkt_i.ctrl.mem_size == MEM_HALF)) |-> (addr[0] == 1'b0))
        else $error("halfword load from odd address %h", addr);

    word_load_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        (is_load && (exe_pkt_i.ctrl.mem_size == MEM_WORD)) |-> (addr[1:0] == 2'b00))
        else $error("word load from unaligned address %h", addr);

    // tag is load_regfile_o and rd as the writeback stage drives them
    no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_busy_rd_i[5] |-> (wb_busy_rd_i[4:0] != 5'd0))
        else $error("register write with rd x0");

    // decode only holds something it accepted, or kept through a stall
    ready_low_only_when_held: assert property (@(posedge clk_i) disable iff (reset_i)
        !instr_ready_i |-> $past(instr_valid_i || !instr_ready_i))
        else $error("instr_ready_o low with an empty holding register");

endmodule

bind rv32i_decode rv32i_backend_props u_props (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_i (instr_ready_o),
    .wb_busy_rd_i  (wb_busy_rd_i),
    .exe_pkt_i     (exe_pkt_o)
);

`default_nettype wire

/* design/rv32i_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_backend import rv32i_pkg::*; #(
    parameter int unsigned DMEM_ADDR_BITS = 8
) (
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire logic        instr_valid_i,
    input  wire logic [31:0] instr_i,
    output logic             instr_ready_o,
    output logic             wb_valid_o,
    output logic [4:0]       wb_rd_o,
    output logic [XLEN-1:0]  wb_data_o
);

    logic [4:0]      rs1_addr, rs2_addr;
    logic [XLEN-1:0] rs1_data, rs2_data;
    logic [XLEN-1:0] mem_rdata;
    logic [5:0]      ex_busy_rd, mem_busy_rd, wb_busy_rd;
    exe_pkt_t        exe_pkt;
    mem_pkt_t        mem_pkt;
    wb_pkt_t         wb_pkt;

    rv32i_decode u_decode (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_busy_rd_i  (ex_busy_rd),
        .mem_busy_rd_i (mem_busy_rd),
        .wb_busy_rd_i  (wb_busy_rd),
        .exe_pkt_o     (exe_pkt)
    );

    rv32i_regfile u_regfile (
        .clk_i      (clk_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_o),
        .rd_i       (wb_rd_o),
        .rd_data_i  (wb_data_o)
    );

    rv32i_execute u_execute (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .exe_pkt_i (exe_pkt),
        .mem_pkt_o (mem_pkt),
        .busy_rd_o (ex_busy_rd)
    );

    rv32i_memory #(
        .DMEM_ADDR_BITS (DMEM_ADDR_BITS)
    ) u_memory (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mem_pkt_i   (mem_pkt),
        .wb_pkt_o    (wb_pkt),
        .mem_rdata_o (mem_rdata),
        .busy_rd_o   (mem_busy_rd)
    );

    rv32i_writeback u_writeback (
        .wb_pkt_i         (wb_pkt),
        .mem_rdata_i      (mem_rdata),
        .load_regfile_o   (wb_valid_o),
        .rd_o             (wb_rd_o),
        .regfilemux_out_o (wb_data_o),
        .busy_rd_o        (wb_busy_rd)
    );

endmodule

`default_nettype wire

/* design/rv32i_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_writeback import rv32i_pkg::*; (
    input  wire wb_pkt_t         wb_pkt_i,
    input  wire logic [XLEN-1:0] mem_rdata_i,
    output logic                 load_regfile_o,
    output logic [4:0]           rd_o,
    output logic [XLEN-1:0]      regfilemux_out_o,
    output logic [5:0]           busy_rd_o
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // lane select from the low address bits
    assign load_byte = mem_rdata_i[{wb_pkt_i.addr[1:0], 3'b000} +: 8];
    assign load_half = mem_rdata_i[{wb_pkt_i.addr[1], 4'b0000} +: 16];

    always_comb begin
        regfilemux_out_o = wb_pkt_i.alu_result;
        unique case (wb_pkt_i.ctrl.regfilemux_sel)
            alu_out: regfilemux_out_o = wb_pkt_i.alu_result;
            br_en:   regfilemux_out_o = {{(XLEN-1){1'b0}}, wb_pkt_i.br_en};
            u_imm:   regfilemux_out_o = wb_pkt_i.u_imm;
            lw:      regfilemux_out_o = mem_rdata_i;
            lh:      regfilemux_out_o = {{16{load_half[15]}}, load_half};
            lhu:     regfilemux_out_o = {16'h0000, load_half};
            lb:      regfilemux_out_o = {{24{load_byte[7]}}, load_byte};
            lbu:     regfilemux_out_o = {24'h000000, load_byte};
        endcase
    end

    assign load_regfile_o = wb_pkt_i.valid && wb_pkt_i.ctrl.load_regfile;
    assign rd_o           = wb_pkt_i.rd;

    // regfile takes the write at the end of this cycle, so still busy here
    assign busy_rd_o = {load_regfile_o, wb_pkt_i.rd};

endmodule

`default_nettype wire

/* design/rv32i_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_memory import rv32i_pkg::*; #(
    parameter int unsigned DMEM_ADDR_BITS = 8
) (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire mem_pkt_t mem_pkt_i,
    output wb_pkt_t       wb_pkt_o,
    output logic [XLEN-1:0] mem_rdata_o,
    output logic [5:0]    busy_rd_o
);

    mem_pkt_t                  mem_q;
    logic [XLEN-1:0]           dmem [0:(1 << DMEM_ADDR_BITS) - 1];
    logic [DMEM_ADDR_BITS-1:0] word_addr;
    logic [3:0]                byte_en;

    assign word_addr = mem_q.addr[DMEM_ADDR_BITS+1:2];

    always_comb begin
        case (mem_q.ctrl.mem_size)
            MEM_BYTE: byte_en = 4'b0001 << mem_q.addr[1:0];
            MEM_HALF: byte_en = mem_q.addr[1] ? 4'b1100 : 4'b0011;
            default:  byte_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_q.valid    <= 1'b0;
            wb_pkt_o.valid <= 1'b0;
        end else begin
            mem_q          <= mem_pkt_i;
            wb_pkt_o.valid <= mem_q.valid;
        end
        wb_pkt_o.ctrl       <= mem_q.ctrl;
        wb_pkt_o.rd         <= mem_q.rd;
        wb_pkt_o.alu_result <= mem_q.alu_result;
        wb_pkt_o.br_en      <= mem_q.br_en;
        wb_pkt_o.u_imm      <= mem_q.u_imm;
        wb_pkt_o.addr       <= mem_q.addr;
    end

    // data ram, read data lines up with wb_pkt_o
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (mem_q.valid && mem_q.ctrl.mem_write && byte_en[i]) begin
                dmem[word_addr][8*i +: 8] <= mem_q.store_data[8*i +: 8];
            end
        end
        if (mem_q.ctrl.mem_read) begin
            mem_rdata_o <= dmem[word_addr];
        end
    end

    assign busy_rd_o = {mem_q.valid && mem_q.ctrl.load_regfile, mem_q.rd};

endmodule

`default_nettype wire

/* design/rv32i_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_execute import rv32i_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire exe_pkt_t exe_pkt_i,
    output mem_pkt_t      mem_pkt_o,
    output logic [5:0]    busy_rd_o
);

    exe_pkt_t        exe_q;
    logic [XLEN-1:0] op_a, op_b, alu_result, store_data;
    logic [4:0]      shamt;
    logic            cmp_result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q <= exe_pkt_i;
        end
    end

    assign op_a  = exe_q.ctrl.alu_src_pc ? exe_q.pc : exe_q.rs1_data;
    assign op_b  = exe_q.ctrl.alu_src_imm ? exe_q.imm : exe_q.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (exe_q.ctrl.alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_sll: alu_result = op_a << shamt;
            alu_srl: alu_result = op_a >> shamt;
            alu_sra: alu_result = $signed(op_a) >>> shamt;
            alu_xor: alu_result = op_a ^ op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_and: alu_result = op_a & op_b;
        endcase
    end

    // slt/sltu and the immediate forms
    assign cmp_result = (exe_q.ctrl.cmp_op == cmp_lt) ? ($signed(op_a) < $signed(op_b))
                                                      : (op_a < op_b);

    // store data copied into every lane, byte enables pick the right one
    always_comb begin
        case (exe_q.ctrl.mem_size)
            MEM_BYTE: store_data = {4{exe_q.rs2_data[7:0]}};
            MEM_HALF: store_data = {2{exe_q.rs2_data[15:0]}};
            default:  store_data = exe_q.rs2_data;
        endcase
    end

    assign mem_pkt_o.valid      = exe_q.valid;
    assign mem_pkt_o.ctrl       = exe_q.ctrl;
    assign mem_pkt_o.rd         = exe_q.rd;
    assign mem_pkt_o.alu_result = alu_result;
    assign mem_pkt_o.br_en      = cmp_result;
    assign mem_pkt_o.u_imm      = exe_q.imm;
    assign mem_pkt_o.addr       = exe_q.rs1_data + exe_q.imm;
    assign mem_pkt_o.store_data = store_data;

    assign busy_rd_o = {exe_q.valid && exe_q.ctrl.load_regfile, exe_q.rd};

endmodule

`default_nettype wire

/* design/rv32i_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_decode import rv32i_pkg::*; (
    input  wire logic            clk_i,
    input  wire logic            reset_i,
    input  wire logic            instr_valid_i,
    input  wire logic [31:0]     instr_i,
    output logic                 instr_ready_o,
    output logic [4:0]           rs1_addr_o,
    output logic [4:0]           rs2_addr_o,
    input  wire logic [XLEN-1:0] rs1_data_i,
    input  wire logic [XLEN-1:0] rs2_data_i,
    input  wire logic [5:0]      ex_busy_rd_i,
    input  wire logic [5:0]      mem_busy_rd_i,
    input  wire logic [5:0]      wb_busy_rd_i,
    output exe_pkt_t             exe_pkt_o
);

    logic            hold_valid;
    logic [31:0]     hold_instr;
    logic [XLEN-1:0] hold_pc;
    logic [XLEN-1:0] pc_q;

    rv32i_opcode_t   opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm_i, imm_s, imm_u, imm;
    ctrl_word_t      ctrl;
    logic            legal, use_rs1, use_rs2, stall;

    function automatic alu_op_t alu_op_from_funct(input logic [2:0] f3, input logic alt);
        unique case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            // slt forms take their result from the comparator
            default: return alu_add;
        endcase
    endfunction

    function automatic logic hazard(input logic [4:0] rs, input logic [5:0] tag);
        return tag[5] && (tag[4:0] == rs) && (rs != 5'd0);
    endfunction

    assign opcode     = rv32i_opcode_t'(hold_instr[6:0]);
    assign funct3     = hold_instr[14:12];
    assign rd         = hold_instr[11:7];
    assign rs1_addr_o = hold_instr[19:15];
    assign rs2_addr_o = hold_instr[24:20];

    assign imm_i = {{20{hold_instr[31]}}, hold_instr[31:20]};
    assign imm_s = {{20{hold_instr[31]}}, hold_instr[31:25], hold_instr[11:7]};
    assign imm_u = {hold_instr[31:12], 12'h000};

    always_comb begin
        ctrl    = '0;
        legal   = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm     = imm_i;
        case (opcode)
            op_lui: begin
                legal               = 1'b1;
                imm                 = imm_u;
                ctrl.regfilemux_sel = u_imm;
                ctrl.load_regfile   = 1'b1;
            end
            op_auipc: begin
                legal               = 1'b1;
                imm                 = imm_u;
                ctrl.alu_src_pc     = 1'b1;
                ctrl.alu_src_imm    = 1'b1;
                ctrl.regfilemux_sel = alu_out;
                ctrl.load_regfile   = 1'b1;
            end
            op_imm, op_reg: begin
                legal            = 1'b1;
                use_rs1          = 1'b1;
                use_rs2          = (opcode == op_reg);
                ctrl.alu_src_imm = (opcode == op_imm);
                // bit 30 is part of the immediate except for srai
                ctrl.alu_op = alu_op_from_funct(funct3,
                    hold_instr[30] && (opcode == op_reg || funct3 == 3'b101));
                ctrl.cmp_op = funct3[0] ? cmp_ltu : cmp_lt;
                ctrl.regfilemux_sel = (funct3[2:1] == 2'b01) ? br_en : alu_out;
                ctrl.load_regfile   = 1'b1;
            end
            op_load: begin
                legal             = 1'b1;
                use_rs1           = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_size     = funct3[1:0];
                ctrl.load_regfile = 1'b1;
                case (funct3)
                    3'b000:  ctrl.regfilemux_sel = lb;
                    3'b001:  ctrl.regfilemux_sel = lh;
                    3'b010:  ctrl.regfilemux_sel = lw;
                    3'b100:  ctrl.regfilemux_sel = lbu;
                    3'b101:  ctrl.regfilemux_sel = lhu;
                    default: legal = 1'b0;
                endcase
            end
            op_store: begin
                legal          = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                imm            = imm_s;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = funct3[1:0];
            end
            default: ;
        endcase
        if (rd == 5'd0) begin
            ctrl.load_regfile = 1'b0;
        end
    end

    // wait until every in-flight producer has reached the register file
    assign stall = hold_valid &&
        ((use_rs1 && (hazard(rs1_addr_o, ex_busy_rd_i) || hazard(rs1_addr_o, mem_busy_rd_i) ||
                      hazard(rs1_addr_o, wb_busy_rd_i))) ||
         (use_rs2 && (hazard(rs2_addr_o, ex_busy_rd_i) || hazard(rs2_addr_o, mem_busy_rd_i) ||
                      hazard(rs2_addr_o, wb_busy_rd_i))));

    assign instr_ready_o = !hold_valid || !stall;

    // illegal words leave the holding register as an invalid packet
    assign exe_pkt_o.valid    = hold_valid && !stall && legal;
    assign exe_pkt_o.ctrl     = ctrl;
    assign exe_pkt_o.rd       = rd;
    assign exe_pkt_o.rs1_data = rs1_data_i;
    assign exe_pkt_o.rs2_data = rs2_data_i;
    assign exe_pkt_o.pc       = hold_pc;
    assign exe_pkt_o.imm      = imm;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hold_valid <= 1'b0;
            hold_instr <= '0;
            hold_pc    <= '0;
            pc_q       <= '0;
        end else begin
            if (instr_ready_o) begin
                hold_valid <= instr_valid_i;
            end
            if (instr_valid_i && instr_ready_o) begin
                hold_instr <= instr_i;
                hold_pc    <= pc_q;
                pc_q       <= pc_q + XLEN'(4);
            end
        end
    end

endmodule

`default_nettype wire

/* design/rv32i_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_regfile import rv32i_pkg::*; (
    input  wire logic            clk_i,
    input  wire logic [4:0]      rs1_addr_i,
    input  wire logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    input  wire logic            we_i,
    input  wire logic [4:0]      rd_i,
    input  wire logic [XLEN-1:0] rd_data_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk_i) begin
        if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= rd_data_i;
        end
    end

endmodule

`default_nettype wire

/* design/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    localparam int XLEN = 32;

    // mem_size encodings, same as funct3[1:0] of loads and stores
    localparam logic [1:0] MEM_BYTE = 2'b00;
    localparam logic [1:0] MEM_HALF = 2'b01;
    localparam logic [1:0] MEM_WORD = 2'b10;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_sll, alu_srl, alu_sra, alu_xor, alu_or, alu_and
    } alu_op_t;

    typedef enum logic {
        cmp_lt,
        cmp_ltu
    } cmp_op_t;

    typedef enum logic [2:0] {
        alu_out, br_en, u_imm, lw, lh, lhu, lb, lbu
    } regfilemux_sel_t;

    typedef struct packed {
        alu_op_t         alu_op;
        cmp_op_t         cmp_op;
        logic            alu_src_imm;
        logic            alu_src_pc;
        logic            mem_read;
        logic            mem_write;
        logic [1:0]      mem_size;
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
    } ctrl_word_t;

    // decode to execute
    typedef struct packed {
        logic            valid;
        ctrl_word_t      ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
    } exe_pkt_t;

    // execute to memory
    typedef struct packed {
        logic            valid;
        ctrl_word_t      ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] alu_result;
        logic            br_en;
        logic [XLEN-1:0] u_imm;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] store_data;
    } mem_pkt_t;

    // memory to writeback, ram read data travels beside it
    typedef struct packed {
        logic            valid;
        ctrl_word_t      ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] alu_result;
        logic            br_en;
        logic [XLEN-1:0] u_imm;
        logic [XLEN-1:0] addr;
    } wb_pkt_t;

endpackage

`default_nettype wire
